// ==== Bender.yml ====
package:
  name: mmu

sources:
  - logic/mmuArchPkg.sv
  - logic/tlbPkg.sv
  - logic/tlbMatch.sv
  - logic/tlbArray.sv
  - logic/tlbMaintCtrl.sv
  - logic/addrTranslate.sv
  - logic/mmuTop.sv
  - target: test
    files:
      - verification/mmu_checker.sv
      - verification/mmuTb.sv

// ==== logic/addrTranslate.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrTranslate (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire mmuArchPkg::xlatReqT xlatReq,
    input  wire mmuArchPkg::crmdT    crmd,
    input  wire mmuArchPkg::dmwT     dmw0,
    input  wire mmuArchPkg::dmwT     dmw1,
    input  wire logic                tlbHit,
    input  wire tlbPkg::tlbEntryT    hitEntry,
    output mmuArchPkg::vaddrT        lookupVa,
    output mmuArchPkg::xlatRspT      xlatRsp
);

    mmuArchPkg::xlatReqT  reqQ;   // stage 1
    mmuArchPkg::xlatRspT  rspNext;
    tlbPkg::tlbPageT      page;
    mmuArchPkg::paddrT    offsetMask;
    mmuArchPkg::paddrT    tlbPaddr;
    mmuArchPkg::ecodeE    ecode;
    mmuArchPkg::esubcodeT esub;
    logic                 raise;
    logic                 isFetch;

    function automatic logic dmwHit(mmuArchPkg::dmwT win, mmuArchPkg::plvT plv,
                                    logic [2:0] vseg);
        return win.vseg == vseg
            && ((win.plv0 && plv == 2'd0) || (win.plv3 && plv == 2'd3));
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            reqQ <= '0;
            xlatRsp <= '0;
        end
        else
        begin
            reqQ <= xlatReq;
            xlatRsp <= rspNext;
        end
    end

    assign lookupVa = reqQ.vaddr;
    assign isFetch = reqQ.access == mmuArchPkg::FETCH;

    always_comb
    begin
        // odd page when va bit ps is set
        page = reqQ.vaddr[hitEntry.ps[4:0]] ? hitEntry.page1 : hitEntry.page0;
        offsetMask = ~(32'hffff_ffff << hitEntry.ps);
        tlbPaddr = ({page.ppn, 12'b0} & ~offsetMask) | (reqQ.vaddr & offsetMask);

        rspNext = '0;
        rspNext.paddrValid = reqQ.valid;
        rspNext.paddr = tlbPaddr;
        rspNext.memType = page.mat;
        raise = 1'b1;
        esub = '0;
        ecode = mmuArchPkg::INT;

        if (crmd.da && !crmd.pg)
        begin
            raise = 1'b0;
            rspNext.paddr = reqQ.vaddr;
            rspNext.memType = isFetch ? crmd.datf : crmd.datm;
        end
        else if (dmwHit(dmw0, crmd.plv, reqQ.vaddr[31:29]))
        begin
            raise = 1'b0;
            rspNext.paddr = {dmw0.pseg, reqQ.vaddr[28:0]};
            rspNext.memType = dmw0.mat;
        end
        else if (dmwHit(dmw1, crmd.plv, reqQ.vaddr[31:29]))
        begin
            raise = 1'b0;
            rspNext.paddr = {dmw1.pseg, reqQ.vaddr[28:0]};
            rspNext.memType = dmw1.mat;
        end
        else if (crmd.plv != 2'd0 && reqQ.vaddr[31])
        begin
            ecode = mmuArchPkg::ADE;
            esub = isFetch ? mmuArchPkg::adefSub : mmuArchPkg::ademSub;
        end
        else if (!tlbHit)
        begin
            ecode = mmuArchPkg::TLBR;
        end
        else if (!page.v)
        begin
            case (reqQ.access)
                mmuArchPkg::FETCH:
                    ecode = mmuArchPkg::PIF;
                mmuArchPkg::LOAD:
                    ecode = mmuArchPkg::PIL;
                default:
                    ecode = mmuArchPkg::PIS;
            endcase
        end
        else if (crmd.plv > page.plv)
        begin
            ecode = mmuArchPkg::PPI;
        end
        else if (reqQ.access == mmuArchPkg::STORE && !page.d)
        begin
            ecode = mmuArchPkg::PME;
        end
        else
        begin
            raise = 1'b0;   // plain tlb hit
        end

        if (raise)
        begin
            rspNext.paddrValid = 1'b0;
            rspNext.paddr = '0;
            rspNext.memType = '0;
            rspNext.excp = '{valid: reqQ.valid, esubcode: esub, ecode: ecode};
        end
    end

endmodule

`default_nettype wire

// ==== logic/mmuArchPkg.sv ====
`default_nettype none

package mmuArchPkg;

    typedef logic [31:0] vaddrT;
    typedef logic [31:0] paddrT;
    typedef logic [9:0]  asidT;
    typedef logic [1:0]  plvT;
    typedef logic [1:0]  matT;
    typedef logic [8:0]  esubcodeT;

    typedef enum logic [1:0] {
        FETCH = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2
    } accessE;

    // CRMD as the CSR holds it with plv in bits 1:0
    typedef struct packed {
        matT  datm;
        matT  datf;
        logic pg;
        logic da;
        logic ie;
        plvT  plv;
    } crmdT;

    typedef struct packed {
        logic [2:0]  vseg;      // va[31:29]
        logic        rsvd28;
        logic [2:0]  pseg;
        logic [18:0] rsvd24To6;
        matT         mat;
        logic        plv3;
        logic [1:0]  rsvd2To1;
        logic        plv0;
    } dmwT;

    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        TLBR = 6'h3f
    } ecodeE;

    localparam esubcodeT adefSub = 9'h000;
    localparam esubcodeT ademSub = 9'h001;

    typedef struct packed {
        logic     valid;
        esubcodeT esubcode;
        ecodeE    ecode;
    } excpT;

    typedef struct packed {
        logic   valid;
        accessE access;
        vaddrT  vaddr;
    } xlatReqT;

    typedef struct packed {
        logic  paddrValid;
        paddrT paddr;
        matT   memType;
        excpT  excp;
    } xlatRspT;

endpackage

`default_nettype wire

// ==== logic/mmuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmuTop #(
    parameter int tlbIndexWidth = 5
) (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire mmuArchPkg::crmdT    crmd,
    input  wire mmuArchPkg::asidT    asid,
    input  wire mmuArchPkg::dmwT     dmw0,
    input  wire mmuArchPkg::dmwT     dmw1,
    input  wire mmuArchPkg::xlatReqT xlatReq,
    output mmuArchPkg::xlatRspT      xlatRsp,
    input  wire logic                cmdReq,
    input  wire tlbPkg::tlbCmdT      cmd,
    output logic                     cmdAck,
    output tlbPkg::srchRspT          srchRsp
);

    localparam int entryCount = 1 << tlbIndexWidth;

    tlbPkg::tlbEntryT         entries [entryCount];
    tlbPkg::tlbEntryT         hitEntry;
    tlbPkg::tlbEntryT         wrEntry;
    tlbPkg::invOpE            invOp;
    mmuArchPkg::asidT         invAsid;
    mmuArchPkg::vaddrT        srchVa;
    mmuArchPkg::vaddrT        lookupVa;
    logic                     wrEn;
    logic                     invEn;
    logic [tlbIndexWidth-1:0] wrIndex;
    logic                     srchHit;
    logic [tlbIndexWidth-1:0] srchIndex;
    logic                     lookupHit;
    logic [tlbIndexWidth-1:0] lookupIndex;

    tlbArray #(.tlbIndexWidth(tlbIndexWidth)) array (
        .clk     (clk),
        .rstN    (rstN),
        .wrEn    (wrEn),
        .wrIndex (wrIndex),
        .wrEntry (wrEntry),
        .invEn   (invEn),
        .invOp   (invOp),
        .invAsid (invAsid),
        .entries (entries)
    );

    // TLBSRCH query
    tlbMatch #(.tlbIndexWidth(tlbIndexWidth)) srchMatch (
        .entries   (entries),
        .queryVa   (srchVa),
        .queryAsid (asid),
        .hit       (srchHit),
        .hitIndex  (srchIndex)
    );

    tlbMatch #(.tlbIndexWidth(tlbIndexWidth)) lookupMatch (
        .entries   (entries),
        .queryVa   (lookupVa),
        .queryAsid (asid),
        .hit       (lookupHit),
        .hitIndex  (lookupIndex)
    );

    assign hitEntry = entries[lookupIndex];

    tlbMaintCtrl #(.tlbIndexWidth(tlbIndexWidth)) maintCtrl (
        .clk       (clk),
        .rstN      (rstN),
        .cmdReq    (cmdReq),
        .cmd       (cmd),
        .asid      (asid),
        .srchHit   (srchHit),
        .srchIndex (srchIndex),
        .srchVa    (srchVa),
        .cmdAck    (cmdAck),
        .srchRsp   (srchRsp),
        .wrEn      (wrEn),
        .wrIndex   (wrIndex),
        .wrEntry   (wrEntry),
        .invEn     (invEn),
        .invOp     (invOp),
        .invAsid   (invAsid)
    );

    addrTranslate xlat (
        .clk      (clk),
        .rstN     (rstN),
        .xlatReq  (xlatReq),
        .crmd     (crmd),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .tlbHit   (lookupHit),
        .hitEntry (hitEntry),
        .lookupVa (lookupVa),
        .xlatRsp  (xlatRsp)
    );

endmodule

`default_nettype wire

// ==== logic/tlbArray.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlbArray #(
    parameter int tlbIndexWidth = 5
) (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire logic                     wrEn,
    input  wire logic [tlbIndexWidth-1:0] wrIndex,
    input  wire tlbPkg::tlbEntryT         wrEntry,
    input  wire logic                     invEn,
    input  wire tlbPkg::invOpE            invOp,
    input  wire mmuArchPkg::asidT         invAsid,
    output tlbPkg::tlbEntryT              entries [1 << tlbIndexWidth]
);

    localparam int entryCount = 1 << tlbIndexWidth;

    tlbPkg::tlbEntryT      payload [entryCount];
    logic [entryCount-1:0] entryValid;   // the live e bits
    logic [entryCount-1:0] invHit;

    always_comb
    begin
        for (int i = 0; i < entryCount; i++)
        begin
            case (invOp)
                tlbPkg::INV_ALL0,
                tlbPkg::INV_ALL1:
                    invHit[i] = 1'b1;
                tlbPkg::INV_GLOBAL:
                    invHit[i] = payload[i].g;
                tlbPkg::INV_NONGLOBAL:
                    invHit[i] = !payload[i].g;
                tlbPkg::INV_ASID:
                    invHit[i] = !payload[i].g && payload[i].asid == invAsid;
                default:
                    invHit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            entryValid <= '0;
        end
        else if (wrEn)
        begin
            entryValid[wrIndex] <= wrEntry.e;
        end
        else if (invEn)
        begin
            entryValid <= entryValid & ~invHit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wrEn)
            payload[wrIndex] <= wrEntry;
    end

    always_comb
    begin
        for (int i = 0; i < entryCount; i++)
        begin
            entries[i] = payload[i];
            entries[i].e = entryValid[i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlbMaintCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlbMaintCtrl #(
    parameter int tlbIndexWidth = 5
) (
    input  wire logic                     clk,
    input  wire logic                     rstN,
    input  wire logic                     cmdReq,
    input  wire tlbPkg::tlbCmdT           cmd,
    input  wire mmuArchPkg::asidT         asid,
    input  wire logic                     srchHit,
    input  wire logic [tlbIndexWidth-1:0] srchIndex,
    output mmuArchPkg::vaddrT             srchVa,
    output logic                          cmdAck,
    output tlbPkg::srchRspT               srchRsp,
    output logic                          wrEn,
    output logic [tlbIndexWidth-1:0]      wrIndex,
    output tlbPkg::tlbEntryT              wrEntry,
    output logic                          invEn,
    output tlbPkg::invOpE                 invOp,
    output mmuArchPkg::asidT              invAsid
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        ACK
    } ctrlStateE;

    ctrlStateE state;
    logic      execNow;

    function automatic tlbPkg::tlbPageT eloToPage(tlbPkg::tlbEloT lo);
        return '{ppn: lo.ppn, plv: lo.plv, mat: lo.mat, d: lo.d, v: lo.v};
    endfunction

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (cmdReq)
                        state <= EXEC;
                EXEC:
                    state <= ACK;   // single execute cycle
                ACK:
                    if (!cmdReq)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign execNow = state == EXEC;
    assign cmdAck = state == ACK;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            srchRsp <= '0;
        else if (execNow && cmd.cmd == tlbPkg::SRCH)
            srchRsp <= '{ne: !srchHit, index: srchHit ? 8'(srchIndex) : 8'd0};
    end

    assign srchVa = {cmd.vppn, 13'b0};

    // cmd is held by the requester until ack
    assign wrEn = execNow && cmd.cmd == tlbPkg::WR;
    assign invEn = execNow && cmd.cmd == tlbPkg::INV;
    assign wrIndex = cmd.index[tlbIndexWidth-1:0];
    assign invOp = cmd.invOp;
    assign invAsid = cmd.invAsid;

    always_comb
    begin
        wrEntry.e = !cmd.ne;
        wrEntry.g = cmd.lo0.g && cmd.lo1.g;   // global only if both halves say so
        wrEntry.asid = asid;
        wrEntry.ps = cmd.ps;
        wrEntry.vppn = cmd.vppn;
        wrEntry.page0 = eloToPage(cmd.lo0);
        wrEntry.page1 = eloToPage(cmd.lo1);
    end

endmodule

`default_nettype wire

// ==== logic/tlbMatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlbMatch #(
    parameter int tlbIndexWidth = 5
) (
    input  wire tlbPkg::tlbEntryT    entries [1 << tlbIndexWidth],
    input  wire mmuArchPkg::vaddrT   queryVa,
    input  wire mmuArchPkg::asidT    queryAsid,
    output logic                     hit,
    output logic [tlbIndexWidth-1:0] hitIndex
);

    localparam int entryCount = 1 << tlbIndexWidth;

    logic [entryCount-1:0] hitVec;

    // one entry covers an even/odd page pair so compare above ps+1
    always_comb
    begin
        for (int i = 0; i < entryCount; i++)
        begin
            hitVec[i] = entries[i].e
                && (entries[i].g || entries[i].asid == queryAsid)
                && (({entries[i].vppn, 13'b0} >> (entries[i].ps + 1))
                    == (queryVa >> (entries[i].ps + 1)));
        end
    end

    assign hit = |hitVec;

    // lowest index wins
    always_comb
    begin
        hitIndex = '0;
        for (int i = entryCount - 1; i >= 0; i--)
        begin
            if (hitVec[i])
                hitIndex = tlbIndexWidth'(i);
        end
    end

endmodule

`default_nettype wire

// ==== logic/tlbPkg.sv ====
`default_nettype none

package tlbPkg;

    typedef logic [5:0]  psT;
    typedef logic [18:0] vppnT;    // va[31:13]
    typedef logic [19:0] ppnT;

    typedef struct packed {
        ppnT             ppn;
        mmuArchPkg::plvT plv;
        mmuArchPkg::matT mat;
        logic            d;
        logic            v;
    } tlbPageT;

    typedef struct packed {
        logic             e;
        logic             g;
        mmuArchPkg::asidT asid;
        psT               ps;
        vppnT             vppn;
        tlbPageT          page0;   // even page
        tlbPageT          page1;
    } tlbEntryT;

    // TLBELO layout
    typedef struct packed {
        logic [3:0]      rsvdHi;
        ppnT             ppn;
        logic            rsvd7;
        logic            g;
        mmuArchPkg::matT mat;
        mmuArchPkg::plvT plv;
        logic            d;
        logic            v;
    } tlbEloT;

    typedef enum logic [1:0] {
        SRCH = 2'd0,
        WR   = 2'd1,
        INV  = 2'd2
    } tlbCmdE;

    typedef enum logic [4:0] {
        INV_ALL0      = 5'd0,
        INV_ALL1      = 5'd1,
        INV_GLOBAL    = 5'd2,
        INV_NONGLOBAL = 5'd3,
        INV_ASID      = 5'd4
    } invOpE;

    typedef struct packed {
        tlbCmdE           cmd;
        invOpE            invOp;
        logic [7:0]       index;
        psT               ps;
        logic             ne;
        vppnT             vppn;
        tlbEloT           lo0;
        tlbEloT           lo1;
        mmuArchPkg::asidT invAsid;
    } tlbCmdT;

    typedef struct packed {
        logic       ne;
        logic [7:0] index;
    } srchRspT;

endpackage

`default_nettype wire

// ==== verification/mmuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmuTb;

    localparam int testCycles = 200;    // all tests take roughly this many cycles
    localparam int cycleLimit = 10 * testCycles;
    localparam mmuArchPkg::matT datfMat = 2'd1;
    localparam mmuArchPkg::matT datmMat = 2'd2;

    typedef struct packed {
        logic                chk;
        mmuArchPkg::xlatRspT rsp;
    } expectT;

    logic                clk;
    logic                rstN;
    mmuArchPkg::crmdT    crmd;
    mmuArchPkg::asidT    asid;
    mmuArchPkg::dmwT     dmw0;
    mmuArchPkg::dmwT     dmw1;
    mmuArchPkg::xlatReqT xlatReq;
    mmuArchPkg::xlatRspT xlatRsp;
    logic                cmdReq;
    tlbPkg::tlbCmdT      cmd;
    logic                cmdAck;
    tlbPkg::srchRspT     srchRsp;

    expectT              expNew;    // set with the request
    expectT              expMid;
    expectT              expOut;    // lines up with xlatRsp
    tlbPkg::srchRspT     expSrch;
    logic                srchChk;
    int                  errCount;
    int                  errMark;
    int                  testCount;
    int                  badTests;
    int                  cycleCount;

    mmuTop #(.tlbIndexWidth(5)) UUT (
        .clk     (clk),
        .rstN    (rstN),
        .crmd    (crmd),
        .asid    (asid),
        .dmw0    (dmw0),
        .dmw1    (dmw1),
        .xlatReq (xlatReq),
        .xlatRsp (xlatRsp),
        .cmdReq  (cmdReq),
        .cmd     (cmd),
        .cmdAck  (cmdAck),
        .srchRsp (srchRsp)
    );

    bind mmuTop mmuChecker protoCheck (
        .clk     (clk),
        .rstN    (rstN),
        .cmdReq  (cmdReq),
        .cmdAck  (cmdAck),
        .xlatRsp (xlatRsp),
        .srchRsp (srchRsp)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < cycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the tests did not finish", cycleLimit);
        $display("test failed");
        $finish;
    end

    // two edges from request to response
    always @(posedge clk)
    begin
        expMid <= expNew;
        expOut <= expMid;
    end

    rspCheck: assert property (@(posedge clk) disable iff (!rstN)
        expOut.chk |-> xlatRsp == expOut.rsp)
    else
    begin
        errCount++;
        $display("error: xlatRsp got %h expected %h",
                 $sampled(xlatRsp), $sampled(expOut.rsp));
    end

    idleCheck: assert property (@(posedge clk) disable iff (!rstN)
        !expOut.chk |-> !xlatRsp.paddrValid && !xlatRsp.excp.valid)
    else
    begin
        errCount++;
        $display("error: xlatRsp.paddrValid %h xlatRsp.excp.valid %h expected 0 0",
                 $sampled(xlatRsp.paddrValid), $sampled(xlatRsp.excp.valid));
    end

    srchCheck: assert property (@(posedge clk) disable iff (!rstN)
        srchChk && cmdAck |-> srchRsp == expSrch)
    else
    begin
        errCount++;
        $display("error: srchRsp got %h expected %h", $sampled(srchRsp), $sampled(expSrch));
    end

    ackLatency: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cmdReq) |-> ##2 $rose(cmdAck))
    else
    begin
        errCount++;
        $display("cmdAck did not rise two cycles after cmdReq was raised");
    end

    function automatic int totalErrors();
        return errCount + UUT.protoCheck.failCount;
    endfunction

    function automatic mmuArchPkg::xlatRspT hitRsp(mmuArchPkg::paddrT pa,
                                                   mmuArchPkg::matT mat);
        hitRsp = '0;
        hitRsp.paddrValid = 1'b1;
        hitRsp.paddr = pa;
        hitRsp.memType = mat;
    endfunction

    function automatic mmuArchPkg::xlatRspT faultRsp(mmuArchPkg::ecodeE code,
                                                     mmuArchPkg::esubcodeT sub);
        faultRsp = '0;
        faultRsp.excp = '{valid: 1'b1, esubcode: sub, ecode: code};
    endfunction

    function automatic mmuArchPkg::ecodeE invalidCode(mmuArchPkg::accessE acc);
        return acc == mmuArchPkg::FETCH ? mmuArchPkg::PIF
            : acc == mmuArchPkg::LOAD ? mmuArchPkg::PIL : mmuArchPkg::PIS;
    endfunction

    function automatic tlbPkg::tlbEloT makeElo(tlbPkg::ppnT ppn, mmuArchPkg::plvT plv,
                                               mmuArchPkg::matT mat, logic d, logic v, logic g);
        return '{rsvdHi: 4'h0, ppn: ppn, rsvd7: 1'b0, g: g, mat: mat, plv: plv, d: d, v: v};
    endfunction

    task automatic translate(input mmuArchPkg::accessE acc, input mmuArchPkg::vaddrT va,
                             input mmuArchPkg::xlatRspT exp);
        @(posedge clk);
        xlatReq <= '{valid: 1'b1, access: acc, vaddr: va};
        expNew <= '{chk: 1'b1, rsp: exp};
    endtask

    task automatic drain();
        @(posedge clk);
        xlatReq.valid <= 1'b0;
        expNew.chk <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    // four-phase req/ack handshake with ack watched on the falling edge
    task automatic runCmd(input tlbPkg::tlbCmdT c, input logic chk, input tlbPkg::srchRspT exp);
        @(posedge clk);
        cmd <= c;
        cmdReq <= 1'b1;
        expSrch <= exp;
        srchChk <= chk;
        do
            @(negedge clk);
        while (!cmdAck);
        @(posedge clk);
        cmdReq <= 1'b0;
        do
            @(negedge clk);
        while (cmdAck);
    endtask

    task automatic writeEntry(input int index, input tlbPkg::vppnT vppn,
                              input tlbPkg::tlbEloT lo0, input tlbPkg::tlbEloT lo1);
        tlbPkg::tlbCmdT c;
        c = '0;
        c.cmd = tlbPkg::WR;
        c.index = 8'(index);
        c.ps = 6'd12;    // 4 KB pages
        c.vppn = vppn;
        c.lo0 = lo0;
        c.lo1 = lo1;
        runCmd(c, 1'b0, '0);
    endtask

    task automatic searchTlb(input tlbPkg::vppnT vppn, input tlbPkg::srchRspT exp);
        tlbPkg::tlbCmdT c;
        c = '0;
        c.cmd = tlbPkg::SRCH;
        c.vppn = vppn;
        runCmd(c, 1'b1, exp);
    endtask

    task automatic invalidate(input tlbPkg::invOpE op, input mmuArchPkg::asidT a);
        tlbPkg::tlbCmdT c;
        c = '0;
        c.cmd = tlbPkg::INV;
        c.invOp = op;
        c.invAsid = a;
        runCmd(c, 1'b0, '0);
    endtask

    task automatic finishTest(input string name);
        int errNow;
        drain();
        errNow = totalErrors();
        testCount++;
        if (errNow != errMark)
            badTests++;
        $display("%s: %0d errors", name, errNow - errMark);
        errMark = errNow;
    endtask

    initial
    begin
        mmuArchPkg::vaddrT  va;
        mmuArchPkg::accessE acc;
        mmuArchPkg::asidT   asidX;
        tlbPkg::vppnT       vppnA;
        tlbPkg::ppnT        ppn0;
        tlbPkg::ppnT        ppnG;
        logic [28:0]        off29;
        logic [11:0]        off12;

        void'($urandom(91019));
        rstN = 1'b0;
        crmd = '{datm: datmMat, datf: datfMat, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'd0};
        asid = '0;
        dmw0 = '0;
        dmw1 = '0;
        xlatReq = '0;
        cmdReq = 1'b0;
        cmd = '0;
        expNew = '0;
        expMid = '0;
        expOut = '0;
        expSrch = '0;
        srchChk = 1'b0;
        errCount = 0;
        errMark = 0;
        testCount = 0;
        badTests = 0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < 6; i++)
        begin
            va = $urandom();
            acc = mmuArchPkg::accessE'($urandom_range(2));
            translate(acc, va, hitRsp(va, acc == mmuArchPkg::FETCH ? datfMat : datmMat));
        end
        finishTest("da mode");

        @(posedge clk);
        crmd.da <= 1'b0;
        crmd.pg <= 1'b1;
        dmw0 <= '{vseg: 3'h4, pseg: 3'h1, mat: 2'd1, plv0: 1'b1, default: '0};
        off29 = 29'($urandom());
        translate(mmuArchPkg::LOAD, {3'h4, off29}, hitRsp({3'h1, off29}, 2'd1));
        drain();
        @(posedge clk);
        crmd.plv <= 2'd3;    // window closed to plv3
        translate(mmuArchPkg::FETCH, {3'h4, off29},
                  faultRsp(mmuArchPkg::ADE, mmuArchPkg::adefSub));
        translate(mmuArchPkg::STORE, {3'h4, off29},
                  faultRsp(mmuArchPkg::ADE, mmuArchPkg::ademSub));
        finishTest("dmw windows");

        @(posedge clk);
        crmd.plv <= 2'd0;
        asidX = 10'($urandom());
        asid <= asidX;
        vppnA = {1'b0, 18'($urandom())};
        ppn0 = 20'($urandom());
        ppnG = ppn0 ^ 20'h2;
        off12 = 12'($urandom());
        writeEntry(3, vppnA, makeElo(ppn0, 2'd0, 2'd1, 1'b1, 1'b1, 1'b0),
                   makeElo(ppn0 ^ 20'h1, 2'd0, 2'd2, 1'b1, 1'b1, 1'b0));
        translate(mmuArchPkg::LOAD, {vppnA, 1'b0, off12}, hitRsp({ppn0, off12}, 2'd1));
        translate(mmuArchPkg::FETCH, {vppnA, 1'b1, off12},
                  hitRsp({ppn0 ^ 20'h1, off12}, 2'd2));
        drain();
        writeEntry(5, vppnA ^ 19'h100, makeElo(ppnG, 2'd0, 2'd3, 1'b1, 1'b1, 1'b1),
                   makeElo(ppnG, 2'd0, 2'd3, 1'b1, 1'b1, 1'b1));
        @(posedge clk);
        asid <= asidX ^ 10'h155;    // global entry ignores asid
        translate(mmuArchPkg::STORE, {vppnA ^ 19'h100, 1'b0, off12},
                  hitRsp({ppnG, off12}, 2'd3));
        finishTest("tlb write and hit");

        @(posedge clk);
        asid <= asidX;
        translate(mmuArchPkg::LOAD, {vppnA ^ 19'h200, 1'b0, off12},
                  faultRsp(mmuArchPkg::TLBR, '0));
        drain();
        // even half invalid, odd half clean
        writeEntry(7, vppnA ^ 19'h400, makeElo(ppn0, 2'd0, 2'd1, 1'b1, 1'b0, 1'b0),
                   makeElo(ppnG, 2'd0, 2'd1, 1'b0, 1'b1, 1'b0));
        for (int i = 0; i < 3; i++)
        begin
            acc = mmuArchPkg::accessE'(i);
            translate(acc, {vppnA ^ 19'h400, 1'b0, off12}, faultRsp(invalidCode(acc), '0));
        end
        translate(mmuArchPkg::STORE, {vppnA ^ 19'h400, 1'b1, off12},
                  faultRsp(mmuArchPkg::PME, '0));
        translate(mmuArchPkg::LOAD, {vppnA ^ 19'h400, 1'b1, off12},
                  hitRsp({ppnG, off12}, 2'd1));
        drain();
        @(posedge clk);
        crmd.plv <= 2'd3;
        translate(mmuArchPkg::LOAD, {vppnA, 1'b0, off12}, faultRsp(mmuArchPkg::PPI, '0));
        finishTest("tlb exceptions");

        @(posedge clk);
        crmd.plv <= 2'd0;
        searchTlb(vppnA, '{ne: 1'b0, index: 8'd3});
        searchTlb(vppnA ^ 19'h200, '{ne: 1'b1, index: 8'd0});
        finishTest("tlbsrch");

        invalidate(tlbPkg::INV_ASID, asidX);
        translate(mmuArchPkg::LOAD, {vppnA, 1'b0, off12}, faultRsp(mmuArchPkg::TLBR, '0));
        translate(mmuArchPkg::LOAD, {vppnA ^ 19'h100, 1'b1, off12},
                  hitRsp({ppnG, off12}, 2'd3));
        drain();
        invalidate(tlbPkg::INV_ALL0, '0);
        translate(mmuArchPkg::LOAD, {vppnA ^ 19'h100, 1'b1, off12},
                  faultRsp(mmuArchPkg::TLBR, '0));
        finishTest("invtlb");

        $display("%0d tests run, %0d with errors, %0d failed checks",
                 testCount, badTests, totalErrors());
        if (totalErrors() == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/mmu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmuChecker (
    input wire logic                clk,
    input wire logic                rstN,
    input wire logic                cmdReq,
    input wire logic                cmdAck,
    input wire mmuArchPkg::xlatRspT xlatRsp,
    input wire tlbPkg::srchRspT     srchRsp
);

    int failCount = 0;

    // ack only answers a pending request
    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(cmdAck) |-> cmdReq)
    else
    begin
        failCount++;
        $error("cmdAck rose while no cmdReq was pending");
    end

    ackReleases: assert property (@(posedge clk) disable iff (!rstN)
        $fell(cmdReq) |-> ##[0:2] !cmdAck)
    else
    begin
        failCount++;
        $error("cmdAck stayed high more than two cycles after cmdReq fell");
    end

    rspExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(xlatRsp.paddrValid && xlatRsp.excp.valid))
    else
    begin
        failCount++;
        $error("xlatRsp carried an address and an exception at once");
    end

    // registers reach zero one edge into reset
    resetQuiet: assert property (@(posedge clk)
        !rstN |=> xlatRsp == '0 && !cmdAck && srchRsp == '0)
    else
    begin
        failCount++;
        $error("outputs were not zero during reset");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/mmuArchPkg.sv
logic/tlbPkg.sv
logic/tlbMatch.sv
logic/tlbArray.sv
logic/tlbMaintCtrl.sv
logic/addrTranslate.sv
logic/mmuTop.sv
verification/mmu_checker.sv
verification/mmuTb.sv
